//--- rv32v_pkg.sv
package rv32v_pkg;

    // one element or one bank word
    typedef logic [31:0] word_t;

    // vector register index
    typedef logic [4:0] vreg_sel_t;

    // width of one vector register in bits
    localparam int VLEN_BITS = 128;

    // element width
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_t;

    // lane ALU operations
    // min and max take their signedness from opunsigned
    typedef enum logic [3:0] {
        VALU_ADD = 4'd0,
        VALU_SUB = 4'd1,
        VALU_AND = 4'd2,
        VALU_OR  = 4'd3,
        VALU_XOR = 4'd4,
        VALU_MIN = 4'd5,
        VALU_MAX = 4'd6,
        VALU_SEQ = 4'd7,
        VALU_SNE = 4'd8,
        VALU_SLT = 4'd9,
        VALU_SLE = 4'd10,
        VALU_SGT = 4'd11
    } valuop_t;

    // functional unit select
    typedef enum logic {
        VFU_ALU = 1'b0,
        VFU_RED = 1'b1
    } vfu_t;

    // micro-op index inside a register group
    typedef logic [1:0] uop_num_t;

    // vector length in elements, 0 to 16
    typedef logic [4:0] vl_t;

endpackage

//--- rv32v_vector_bank.sv
`timescale 1ns/1ps

module rv32v_vector_bank #(
    parameter int NUM_REGS = 32
) (
    input  logic                CLK,
    input  logic                rst,
    input  rv32v_pkg::vreg_sel_t vs1,
    input  rv32v_pkg::vreg_sel_t vs2,
    input  rv32v_pkg::vreg_sel_t vw,
    input  rv32v_pkg::word_t    vwdata,
    input  logic [3:0]          byte_wen,
    output rv32v_pkg::word_t    vdat1,
    output rv32v_pkg::word_t    vdat2,
    output rv32v_pkg::word_t    v0
);
    import rv32v_pkg::*;

    // this bank's 32-bit slice of every vector register
    word_t regs [NUM_REGS];

    // byte-enabled write, visible to reads one cycle later
    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (byte_wen[b]) begin
                    regs[vw][b*8 +: 8] <= vwdata[b*8 +: 8];
                end
            end
        end
    end

    // two asynchronous read ports
    assign vdat1 = regs[vs1];
    assign vdat2 = regs[vs2];

    // mask register always visible to the mask unit
    assign v0 = regs[0];

endmodule

//--- rv32v_read_xbar.sv
`timescale 1ns/1ps

module rv32v_read_xbar (
    input  rv32v_pkg::word_t [3:0] bank_dat,
    input  rv32v_pkg::sew_t        veew,
    input  rv32v_pkg::uop_num_t    bank_offset,
    input  logic                   sign_ext,
    output rv32v_pkg::word_t [3:0] out_dat
);
    import rv32v_pkg::*;

    // full register, bank 0 in the low word
    logic [VLEN_BITS-1:0] vreg;

    assign vreg = bank_dat;

    for (genvar k = 0; k < 4; k++) begin : g_lane
        // byte index of this lane's element, wrapping within the register
        logic [3:0]  pos8;
        logic [3:0]  pos16;
        logic [7:0]  elem8;
        logic [15:0] elem16;
        word_t       ext_val;

        // element u*4+k at one byte per element
        assign pos8  = {bank_offset, 2'(k)};
        // element u*4+k at two bytes per element
        assign pos16 = {bank_offset[0], 2'(k), 1'b0};

        assign elem8  = vreg[pos8*8 +: 8];
        assign elem16 = vreg[pos16*8 +: 16];

        always_comb begin
            case (veew)
                SEW8: begin
                    ext_val = sign_ext ? {{24{elem8[7]}}, elem8} : {24'b0, elem8};
                end
                SEW16: begin
                    ext_val = sign_ext ? {{16{elem16[15]}}, elem16} : {16'b0, elem16};
                end
                default: begin
                    // one element per bank, offset has no effect
                    ext_val = bank_dat[k];
                end
            endcase
        end

        assign out_dat[k] = ext_val;
    end

endmodule

//--- rv32v_vfu.sv
`timescale 1ns/1ps

module rv32v_vfu (
    input  rv32v_pkg::word_t   vopA,
    input  rv32v_pkg::word_t   vopB,
    input  logic               mask_bit,
    input  rv32v_pkg::sew_t    vsew,
    input  rv32v_pkg::valuop_t valuop,
    input  logic               vopunsigned,
    output rv32v_pkg::word_t   vres
);
    import rv32v_pkg::*;

    logic  eq;
    logic  lt_s;
    logic  lt_u;
    logic  lt;
    word_t alu_res;
    word_t narrow_res;

    // operands arrive extended, so a 32-bit compare is exact
    assign eq   = (vopA == vopB);
    assign lt_s = ($signed(vopA) < $signed(vopB));
    assign lt_u = (vopA < vopB);
    assign lt   = vopunsigned ? lt_u : lt_s;

    always_comb begin
        case (valuop)
            VALU_ADD: begin
                alu_res = vopA + vopB;
            end
            VALU_SUB: begin
                alu_res = vopA - vopB;
            end
            VALU_AND: begin
                alu_res = vopA & vopB;
            end
            VALU_OR: begin
                alu_res = vopA | vopB;
            end
            VALU_XOR: begin
                alu_res = vopA ^ vopB;
            end
            VALU_MIN: begin
                alu_res = lt ? vopA : vopB;
            end
            VALU_MAX: begin
                alu_res = lt ? vopB : vopA;
            end
            // compares give a single 0 or 1
            VALU_SEQ: begin
                alu_res = {31'b0, eq};
            end
            VALU_SNE: begin
                alu_res = {31'b0, !eq};
            end
            VALU_SLT: begin
                alu_res = {31'b0, lt};
            end
            VALU_SLE: begin
                alu_res = {31'b0, lt || eq};
            end
            VALU_SGT: begin
                alu_res = {31'b0, !(lt || eq)};
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    // back to element width, then sign-extended again
    always_comb begin
        case (vsew)
            SEW8: begin
                narrow_res = {{24{alu_res[7]}}, alu_res[7:0]};
            end
            SEW16: begin
                narrow_res = {{16{alu_res[15]}}, alu_res[15:0]};
            end
            default: begin
                narrow_res = alu_res;
            end
        endcase
    end

    // masked-off lane keeps the old value
    assign vres = mask_bit ? narrow_res : vopA;

endmodule

//--- rv32v_mask_unit.sv
`timescale 1ns/1ps

module rv32v_mask_unit #(
    parameter int NUM_LANES = 4
) (
    input  logic [rv32v_pkg::VLEN_BITS-1:0] v0,
    input  logic                            mask_enable,
    input  rv32v_pkg::uop_num_t             uop_num,
    input  rv32v_pkg::vl_t                  vl,
    output logic [NUM_LANES-1:0]            lane_mask,
    output logic [NUM_LANES-1:0]            mask_bits
);
    import rv32v_pkg::*;

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        // element handled by lane k in this micro-op
        logic [$clog2(VLEN_BITS)-1:0] elem_idx;
        logic                         in_body;

        assign elem_idx = ($clog2(VLEN_BITS))'(int'(uop_num) * NUM_LANES + k);

        // tail elements at or past vl stay inactive
        assign in_body = (elem_idx < {{($clog2(VLEN_BITS) - $bits(vl_t)){1'b0}}, vl});

        // v0 bit only, all ones when unmasked
        assign mask_bits[k] = !mask_enable || v0[elem_idx];

        assign lane_mask[k] = in_body && mask_bits[k];
    end

endmodule

//--- rv32v_reduction_unit.sv
`timescale 1ns/1ps

module rv32v_reduction_unit #(
    parameter int NUM_LANES = 4
) (
    input  rv32v_pkg::valuop_t               valuop,
    input  logic                             vopunsigned,
    input  rv32v_pkg::word_t [NUM_LANES-1:0] vdat_in,
    input  rv32v_pkg::word_t                 vacc,
    input  logic [NUM_LANES-1:0]             vmask_in,
    output rv32v_pkg::word_t                 vdat_out
);
    import rv32v_pkg::*;

    word_t pad_word;
    word_t acc;

    // one step of the fold
    function automatic word_t red_op(input word_t a, input word_t b,
                                     input valuop_t op, input logic uns);
        logic a_lt_b;
        a_lt_b = uns ? (a < b) : ($signed(a) < $signed(b));
        case (op)
            VALU_AND: red_op = a & b;
            VALU_OR:  red_op = a | b;
            VALU_XOR: red_op = a ^ b;
            VALU_MIN: red_op = a_lt_b ? a : b;
            VALU_MAX: red_op = a_lt_b ? b : a;
            default:  red_op = a + b;
        endcase
    endfunction

    // identity value for inactive lanes
    always_comb begin
        case (valuop)
            VALU_AND: begin
                pad_word = '1;
            end
            VALU_MIN: begin
                // largest value loses nothing in a min
                pad_word = vopunsigned ? 32'hffff_ffff : 32'h7fff_ffff;
            end
            VALU_MAX: begin
                pad_word = vopunsigned ? 32'h0000_0000 : 32'h8000_0000;
            end
            default: begin
                pad_word = '0;
            end
        endcase
    end

    // scalar accumulator first, then lanes 0 upward
    always_comb begin
        acc = vacc;
        for (int k = 0; k < NUM_LANES; k++) begin
            acc = red_op(acc, vmask_in[k] ? vdat_in[k] : pad_word, valuop, vopunsigned);
        end
    end

    assign vdat_out = acc;

endmodule

//--- rv32v_ex_datapath.sv
`timescale 1ns/1ps

module rv32v_ex_datapath #(
    parameter int NUM_LANES = 4,
    parameter int NUM_REGS  = 32
) (
    input  logic                             CLK,
    input  logic                             rst,
    input  logic                             in_valid,
    input  rv32v_pkg::vreg_sel_t             vs1_sel,
    input  rv32v_pkg::vreg_sel_t             vs2_sel,
    input  rv32v_pkg::vreg_sel_t             vd_sel,
    input  rv32v_pkg::vfu_t                  vfu_sel,
    input  rv32v_pkg::valuop_t               valuop,
    input  logic                             vopunsigned,
    input  rv32v_pkg::sew_t                  vsew,
    input  logic                             vsignext,
    input  logic                             vmask_en,
    input  rv32v_pkg::uop_num_t              vuop_num,
    input  rv32v_pkg::vl_t                   vl,
    input  logic [4:0]                       vimm,
    input  logic                             vxin1_use_imm,
    input  logic                             vxin1_use_rs1,
    input  rv32v_pkg::word_t                 rdat1,
    input  logic                             out_stall,
    input  rv32v_pkg::vreg_sel_t             wr_sel,
    input  rv32v_pkg::word_t [3:0]           wr_data,
    input  logic [3:0][3:0]                  wr_byte_wen,
    output logic                             out_valid,
    output rv32v_pkg::word_t [NUM_LANES-1:0] out_res,
    output logic [NUM_LANES-1:0]             out_lane_mask,
    output rv32v_pkg::vreg_sel_t             out_vd,
    output rv32v_pkg::uop_num_t              out_uop_num,
    output rv32v_pkg::sew_t                  out_sew
);
    import rv32v_pkg::*;

    logic [VLEN_BITS-1:0]   v0;
    word_t [3:0]            bank_src1;
    word_t [3:0]            bank_src2;
    word_t [3:0]            xbar_src1;
    word_t [3:0]            xbar_src2;
    word_t [NUM_LANES-1:0]  vop_a;
    word_t [NUM_LANES-1:0]  vop_b;
    word_t [NUM_LANES-1:0]  vfu_res;
    word_t                  red_res;
    word_t                  ext_imm;
    word_t                  ext_rs1;
    logic                   vint_cmp;
    logic [NUM_LANES-1:0]   lane_mask;
    logic [NUM_LANES-1:0]   mask_bits;
    word_t [NUM_LANES-1:0]  res_d;
    logic [NUM_LANES-1:0]   lane_mask_d;
    logic                   capture;

    // bank k holds bits 32k+31..32k of every register
    for (genvar b = 0; b < 4; b++) begin : g_bank
        rv32v_vector_bank #(
            .NUM_REGS(NUM_REGS)
        ) i_bank (
            .CLK(CLK),
            .rst(rst),
            .vs1(vs1_sel),
            .vs2(vs2_sel),
            .vw(wr_sel),
            .vwdata(wr_data[b]),
            .byte_wen(wr_byte_wen[b]),
            .vdat1(bank_src1[b]),
            .vdat2(bank_src2[b]),
            .v0(v0[b*32 +: 32])
        );
    end

    rv32v_read_xbar i_xbar_src1 (
        .bank_dat(bank_src1),
        .veew(vsew),
        .bank_offset(vuop_num),
        .sign_ext(vsignext),
        .out_dat(xbar_src1)
    );

    rv32v_read_xbar i_xbar_src2 (
        .bank_dat(bank_src2),
        .veew(vsew),
        .bank_offset(vuop_num),
        .sign_ext(vsignext),
        .out_dat(xbar_src2)
    );

    // compares always take a signed immediate
    assign vint_cmp = valuop inside {VALU_SEQ, VALU_SNE, VALU_SLT, VALU_SLE, VALU_SGT};

    assign ext_imm = (vsignext || vint_cmp) ? {{27{vimm[4]}}, vimm} : {27'b0, vimm};

    // scalar cut down to element width
    always_comb begin
        case (vsew)
            SEW8: begin
                ext_rs1 = vsignext ? {{24{rdat1[7]}}, rdat1[7:0]} : {24'b0, rdat1[7:0]};
            end
            SEW16: begin
                ext_rs1 = vsignext ? {{16{rdat1[15]}}, rdat1[15:0]} : {16'b0, rdat1[15:0]};
            end
            default: begin
                ext_rs1 = rdat1;
            end
        endcase
    end

    // operand B source, operand A is always vs2
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            vop_a[k] = xbar_src2[k];
            if (vxin1_use_imm) begin
                vop_b[k] = ext_imm;
            end else if (vxin1_use_rs1) begin
                vop_b[k] = ext_rs1;
            end else begin
                vop_b[k] = xbar_src1[k];
            end
        end
    end

    rv32v_mask_unit #(
        .NUM_LANES(NUM_LANES)
    ) i_mask_unit (
        .v0(v0),
        .mask_enable(vmask_en),
        .uop_num(vuop_num),
        .vl(vl),
        .lane_mask(lane_mask),
        .mask_bits(mask_bits)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_vfu
        rv32v_vfu i_vfu (
            .vopA(vop_a[k]),
            .vopB(vop_b[k]),
            .mask_bit(mask_bits[k]),
            .vsew(vsew),
            .valuop(valuop),
            .vopunsigned(vopunsigned),
            .vres(vfu_res[k])
        );
    end

    // lane 0 of operand B seeds the fold
    rv32v_reduction_unit #(
        .NUM_LANES(NUM_LANES)
    ) i_reduction_unit (
        .valuop(valuop),
        .vopunsigned(vopunsigned),
        .vdat_in(vop_a),
        .vacc(vop_b[0]),
        .vmask_in(lane_mask),
        .vdat_out(red_res)
    );

    // reductions write a single element
    always_comb begin
        if (vfu_sel == VFU_RED) begin
            res_d       = '0;
            res_d[0]    = red_res;
            lane_mask_d = {{(NUM_LANES - 1){1'b0}}, 1'b1};
        end else begin
            res_d       = vfu_res;
            lane_mask_d = lane_mask;
        end
    end

    assign capture = in_valid && !out_stall;

    // output stage toward memory, held while stalled
    always_ff @(posedge CLK) begin
        if (rst) begin
            out_valid     <= 1'b0;
            out_lane_mask <= '0;
        end else if (!out_stall) begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_lane_mask <= lane_mask_d;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (capture) begin
            out_res     <= res_d;
            out_vd      <= vd_sel;
            out_uop_num <= vuop_num;
            out_sew     <= vsew;
        end
    end

endmodule

//--- tb_rv32v_ex_datapath.sv
`timescale 1ns/1ps

module tb_rv32v_ex_datapath;
    import rv32v_pkg::*;

    localparam int NUM_OPS    = 8 + 32 + 12 + 8 + 16 + 6;
    localparam int MAX_CYCLES = 20 * NUM_OPS + 100;
    localparam int SRC_REG    = 0;
    localparam int SRC_IMM    = 1;
    localparam int SRC_RS1    = 2;

    logic            CLK;
    logic            rst;
    logic            in_valid;
    vreg_sel_t       vs1_sel;
    vreg_sel_t       vs2_sel;
    vreg_sel_t       vd_sel;
    vfu_t            vfu_sel;
    valuop_t         valuop;
    logic            vopunsigned;
    sew_t            vsew;
    logic            vsignext;
    logic            vmask_en;
    uop_num_t        vuop_num;
    vl_t             vl;
    logic [4:0]      vimm;
    logic            vxin1_use_imm;
    logic            vxin1_use_rs1;
    word_t           rdat1;
    logic            out_stall;
    vreg_sel_t       wr_sel;
    word_t [3:0]     wr_data;
    logic [3:0][3:0] wr_byte_wen;
    logic            out_valid;
    word_t [3:0]     out_res;
    logic [3:0]      out_lane_mask;
    vreg_sel_t       out_vd;
    uop_num_t        out_uop_num;
    sew_t            out_sew;

    // reference copy of every vector register
    logic [127:0] model [32];
    word_t        exp_q [$];
    logic [3:0]   exp_mask_q [$];
    vreg_sel_t    exp_vd_q [$];
    uop_num_t     exp_uop_q [$];
    sew_t         exp_sew_q [$];
    word_t        last_res [4];
    logic [3:0]   last_mask;
    vreg_sel_t    last_vd;
    uop_num_t     last_uop;
    sew_t         last_sew;
    int           cycles = 0;

    rv32v_ex_datapath #(
        .NUM_LANES(4),
        .NUM_REGS(32)
    ) i_rv32v_ex_datapath (.*);

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            report_failure("simulation ran past its cycle limit");
        end
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_mask(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_vreg(input string name, input vreg_sel_t got, input vreg_sel_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_uop(input string name, input uop_num_t got, input uop_num_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_sew(input string name, input sew_t got, input sew_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic word_t extend_to_word(input word_t v, input sew_t sew, input logic sx);
        case (sew)
            SEW8:    return sx ? {{24{v[7]}}, v[7:0]} : {24'b0, v[7:0]};
            SEW16:   return sx ? {{16{v[15]}}, v[15:0]} : {16'b0, v[15:0]};
            default: return v;
        endcase
    endfunction

    // element idx at byte offset idx*SEW/8, inside the register of the group that holds it
    function automatic word_t elem_ref(input logic [127:0] r, input sew_t sew, input int idx,
                                       input logic sx);
        int nbytes;
        nbytes = (sew == SEW8) ? 1 : ((sew == SEW16) ? 2 : 4);
        return extend_to_word(word_t'(r >> (((idx * nbytes) % 16) * 8)), sew, sx);
    endfunction

    function automatic word_t alu_ref(input word_t a, input word_t b, input valuop_t op,
                                      input logic uns, input sew_t sew);
        logic  less;
        word_t r;
        less = uns ? (a < b) : ($signed(a) < $signed(b));
        case (op)
            VALU_ADD: r = a + b;
            VALU_SUB: r = a - b;
            VALU_AND: r = a & b;
            VALU_OR:  r = a | b;
            VALU_XOR: r = a ^ b;
            VALU_MIN: r = less ? a : b;
            VALU_MAX: r = less ? b : a;
            VALU_SEQ: r = {31'b0, a == b};
            VALU_SNE: r = {31'b0, a != b};
            VALU_SLT: r = {31'b0, less};
            VALU_SLE: r = {31'b0, less || (a == b)};
            default:  r = {31'b0, !less && (a != b)};
        endcase
        return extend_to_word(r, sew, 1'b1);
    endfunction

    // value that leaves a reduction unchanged
    function automatic word_t identity(input valuop_t op, input logic uns);
        case (op)
            VALU_AND: return 32'hffff_ffff;
            VALU_MIN: return uns ? 32'hffff_ffff : 32'h7fff_ffff;
            VALU_MAX: return uns ? 32'h0000_0000 : 32'h8000_0000;
            default:  return 32'h0000_0000;
        endcase
    endfunction

    function automatic logic [127:0] rand128();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic write_vreg(input vreg_sel_t sel, input logic [127:0] data,
                              input logic [15:0] wen);
        @(posedge CLK);
        wr_sel      <= sel;
        wr_data     <= data;
        wr_byte_wen <= wen;
        for (int i = 0; i < 16; i++) begin
            if (wen[i]) begin
                model[sel][i*8 +: 8] = data[i*8 +: 8];
            end
        end
        @(posedge CLK);
        wr_byte_wen <= '0;
    endtask

    task automatic issue_op(
        input vfu_t       vfu,
        input valuop_t    op,
        input logic       uns,
        input sew_t       sew,
        input logic       sx,
        input vreg_sel_t  vs1,
        input vreg_sel_t  vs2,
        input logic       men,
        input uop_num_t   u,
        input vl_t        len,
        input int         src,
        input logic [4:0] imm,
        input word_t      scalar
    );
        word_t      a;
        word_t      b;
        word_t      acc;
        word_t      res [4];
        logic [3:0] act;
        logic       v0_bit;
        logic       cmp;
        int         e;
        vreg_sel_t  vd;
        cmp = op inside {VALU_SEQ, VALU_SNE, VALU_SLT, VALU_SLE, VALU_SGT};
        // destination kept apart from both sources
        vd = ~vs2;
        acc = '0;
        for (int k = 0; k < 4; k++) begin
            e = int'(u) * 4 + k;
            v0_bit = !men || model[0][e];
            act[k] = (e < int'(len)) && v0_bit;
            a = elem_ref(model[vs2], sew, e, sx);
            if (src == SRC_IMM) begin
                b = (sx || cmp) ? {{27{imm[4]}}, imm} : {27'b0, imm};
            end else if (src == SRC_RS1) begin
                b = extend_to_word(scalar, sew, sx);
            end else begin
                b = elem_ref(model[vs1], sew, e, sx);
            end
            // lane 0 operand B seeds the fold
            if (k == 0) begin
                acc = b;
            end
            acc = alu_ref(acc, act[k] ? a : identity(op, uns), op, uns, SEW32);
            res[k] = v0_bit ? alu_ref(a, b, op, uns, sew) : a;
        end
        if (vfu == VFU_RED) begin
            res = '{acc, '0, '0, '0};
            act = 4'b0001;
        end
        @(posedge CLK);
        in_valid      <= 1'b1;
        vfu_sel       <= vfu;
        valuop        <= op;
        vopunsigned   <= uns;
        vsew          <= sew;
        vsignext      <= sx;
        vs1_sel       <= vs1;
        vs2_sel       <= vs2;
        vd_sel        <= vd;
        vmask_en      <= men;
        vuop_num      <= u;
        vl            <= len;
        vxin1_use_imm <= (src == SRC_IMM);
        vxin1_use_rs1 <= (src == SRC_RS1);
        vimm          <= imm;
        rdat1         <= scalar;
        for (int k = 0; k < 4; k++) begin
            exp_q.push_back(res[k]);
        end
        exp_mask_q.push_back(act);
        exp_vd_q.push_back(vd);
        exp_uop_q.push_back(u);
        exp_sew_q.push_back(sew);
    endtask

    task automatic idle_cycle();
        @(posedge CLK);
        in_valid <= 1'b0;
    endtask

    // result of the oldest pending op, one edge after its capture
    task automatic check_next();
        @(negedge CLK);
        if (exp_mask_q.size() == 0) begin
            report_failure("a result was checked with no operation pending");
        end
        check_flag("out_valid", out_valid, 1'b1);
        for (int k = 0; k < 4; k++) begin
            last_res[k] = exp_q.pop_front();
            check_word($sformatf("out_res[%0d]", k), out_res[k], last_res[k]);
        end
        last_mask = exp_mask_q.pop_front();
        check_mask("out_lane_mask", out_lane_mask, last_mask);
        last_vd = exp_vd_q.pop_front();
        check_vreg("out_vd", out_vd, last_vd);
        last_uop = exp_uop_q.pop_front();
        check_uop("out_uop_num", out_uop_num, last_uop);
        last_sew = exp_sew_q.pop_front();
        check_sew("out_sew", out_sew, last_sew);
    endtask

    // output register must still show the last result
    task automatic check_held();
        @(negedge CLK);
        check_flag("out_valid", out_valid, 1'b1);
        for (int k = 0; k < 4; k++) begin
            check_word($sformatf("out_res[%0d]", k), out_res[k], last_res[k]);
        end
        check_mask("out_lane_mask", out_lane_mask, last_mask);
        check_vreg("out_vd", out_vd, last_vd);
        check_uop("out_uop_num", out_uop_num, last_uop);
        check_sew("out_sew", out_sew, last_sew);
    endtask

    function automatic vreg_sel_t pick_reg();
        return vreg_sel_t'($urandom_range(8, 1));
    endfunction

    task automatic byte_write_add_sew32();
        for (int r = 1; r < 9; r++) begin
            write_vreg(vreg_sel_t'(r), rand128(), 16'hffff);
        end
        // partial byte writes over full ones
        write_vreg(5'd3, rand128(), 16'h0f3c);
        write_vreg(5'd5, rand128(), 16'ha5a5);
        for (int i = 0; i < 8; i++) begin
            issue_op(VFU_ALU, i[0] ? VALU_SUB : VALU_ADD, 1'b0, SEW32, 1'b0, pick_reg(),
                     pick_reg(), 1'b0, uop_num_t'(i), vl_t'(16), SRC_REG, 5'd0, '0);
            idle_cycle();
            check_next();
        end
    endtask

    task automatic narrow_elements();
        for (int i = 0; i < 32; i++) begin
            issue_op(VFU_ALU, i[0] ? VALU_MAX : VALU_XOR, !i[3], i[4] ? SEW16 : SEW8, i[3],
                     pick_reg(), pick_reg(), 1'b0, uop_num_t'(i[2:1]), vl_t'(16), SRC_REG,
                     5'd0, '0);
            idle_cycle();
            check_next();
        end
    endtask

    task automatic imm_scalar_compares();
        valuop_t op;
        write_vreg(5'd9, 128'h80000000_0000000f_00000003_fffffffe, 16'hffff);
        for (int i = 0; i < 12; i++) begin
            op = (i % 3 == 0) ? VALU_SLT : ((i % 3 == 1) ? VALU_SEQ : VALU_SGT);
            // upper scalar bits only matter if SEW8 fails to cut them off
            issue_op(VFU_ALU, op, i[0], (i < 6) ? SEW32 : SEW8, i[1], 5'd1, 5'd9, 1'b0,
                     2'd0, vl_t'(16), ((i / 3) % 2 == 1) ? SRC_RS1 : SRC_IMM, 5'h1e,
                     (i < 6) ? 32'd3 : 32'h1234_5603);
            idle_cycle();
            check_next();
        end
    endtask

    task automatic masking_and_tail();
        write_vreg(5'd0, rand128(), 16'hffff);
        for (int i = 0; i < 8; i++) begin
            issue_op(VFU_ALU, VALU_ADD, 1'b0, SEW8, 1'b1, pick_reg(), pick_reg(), 1'b1,
                     uop_num_t'(i), vl_t'($urandom_range(15, 0)), SRC_REG, 5'd0, '0);
            idle_cycle();
            check_next();
        end
    endtask

    task automatic reduction_ops();
        valuop_t op;
        for (int i = 0; i < 16; i++) begin
            op = (i % 4 == 0) ? VALU_ADD : ((i % 4 == 1) ? VALU_AND :
                 ((i % 4 == 2) ? VALU_MIN : VALU_MAX));
            issue_op(VFU_RED, op, i[2], SEW32, 1'b1, pick_reg(), pick_reg(), 1'b1,
                     uop_num_t'($urandom_range(3, 0)), vl_t'($urandom_range(16, 0)),
                     SRC_RS1, 5'd0, $urandom());
            idle_cycle();
            check_next();
        end
    endtask

    task automatic pipeline_and_stall();
        // back to back, each result one edge after its issue
        for (int i = 0; i < 4; i++) begin
            issue_op(VFU_ALU, i[0] ? VALU_XOR : VALU_ADD, 1'b0, SEW16, 1'b1, pick_reg(),
                     pick_reg(), 1'b0, uop_num_t'(i), vl_t'(16), SRC_REG, 5'd0, '0);
            if (i > 0) begin
                check_next();
            end
        end
        idle_cycle();
        check_next();
        issue_op(VFU_ALU, VALU_ADD, 1'b0, SEW32, 1'b0, 5'd1, 5'd2, 1'b0, 2'd0, vl_t'(16),
                 SRC_REG, 5'd0, '0);
        issue_op(VFU_ALU, VALU_SUB, 1'b0, SEW32, 1'b0, 5'd3, 5'd4, 1'b0, 2'd0, vl_t'(16),
                 SRC_REG, 5'd0, '0);
        out_stall <= 1'b1;
        check_next();
        // second op waits at the inputs, first result must hold
        repeat (3) begin
            check_held();
        end
        @(posedge CLK);
        out_stall <= 1'b0;
        idle_cycle();
        check_next();
    endtask

    initial begin
        void'($urandom(22));
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        rst           = 1'b1;
        in_valid      = 1'b0;
        vs1_sel       = '0;
        vs2_sel       = '0;
        vd_sel        = '0;
        vfu_sel       = VFU_ALU;
        valuop        = VALU_ADD;
        vopunsigned   = 1'b0;
        vsew          = SEW32;
        vsignext      = 1'b0;
        vmask_en      = 1'b0;
        vuop_num      = '0;
        vl            = '0;
        vimm          = '0;
        vxin1_use_imm = 1'b0;
        vxin1_use_rs1 = 1'b0;
        rdat1         = '0;
        out_stall     = 1'b0;
        wr_sel        = '0;
        wr_data       = '0;
        wr_byte_wen   = '0;
        repeat (4) @(posedge CLK);
        rst <= 1'b0;
        @(negedge CLK);
        check_flag("out_valid", out_valid, 1'b0);
        check_mask("out_lane_mask", out_lane_mask, 4'b0000);
        byte_write_add_sew32();
        narrow_elements();
        imm_scalar_compares();
        masking_and_tail();
        reduction_ops();
        pipeline_and_stall();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- rv32v_ex_datapath.f
rv32v_pkg.sv
rv32v_vector_bank.sv
rv32v_read_xbar.sv
rv32v_vfu.sv
rv32v_mask_unit.sv
rv32v_reduction_unit.sv
rv32v_ex_datapath.sv
tb_rv32v_ex_datapath.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_rv32v_ex_datapath \
    -f rv32v_ex_datapath.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0
